// File: rename_pkg.sv
// register rename shared definitions
package rename_pkg;

    localparam int arch_regs = 32;
    localparam int rob_depth = 8;
    localparam int checkpoint_count = 4;

    typedef logic [$clog2(arch_regs)-1:0] reg_idx_t;
    // tag 0 means the value sits in the register file
    typedef logic [$clog2(rob_depth):0] rob_tag_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_slot_t;
    typedef logic [$clog2(rob_depth):0] rob_count_t;
    typedef logic [$clog2(checkpoint_count)-1:0] cp_idx_t;

    typedef struct packed {
        rob_tag_t tag;
        logic     ready;
    } map_entry_t;

    typedef map_entry_t [arch_regs-1:0] map_array_t;

    typedef struct packed {
        logic     has_dest;
        reg_idx_t dest_reg;
        logic     rs1_valid;
        reg_idx_t rs1_reg;
        logic     rs2_valid;
        reg_idx_t rs2_reg;
        logic     is_branch;
    } dispatch_packet_t;

    typedef struct packed {
        map_entry_t entry_a;
        map_entry_t entry_b;
        rob_tag_t   new_tag;
    } operand_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } cdb_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     has_dest;
        reg_idx_t dest_reg;
    } retire_packet_t;

    typedef struct packed {
        logic     valid;
        logic     mispredict;
        rob_tag_t tag;
    } resolve_packet_t;

    function automatic rob_slot_t tag_to_slot(rob_tag_t tag);
        return rob_slot_t'(tag - rob_tag_t'(1));
    endfunction

    function automatic rob_tag_t slot_to_tag(rob_slot_t slot);
        return rob_tag_t'(slot) + rob_tag_t'(1);
    endfunction

    // true when tag lies in (branch_tag, tail_tag] walking the ring
    function automatic logic tag_in_flight_after(rob_tag_t tag, rob_tag_t branch_tag,
                                                 rob_tag_t tail_tag);
        rob_slot_t tag_dist;
        rob_slot_t tail_dist;
        tag_dist = tag_to_slot(tag) - tag_to_slot(branch_tag);
        tail_dist = tag_to_slot(tail_tag) - tag_to_slot(branch_tag);
        return (tag != '0) && (tag_dist != '0) && (tag_dist <= tail_dist);
    endfunction

    // cdb wakeup, then retire clear, over a whole map
    function automatic map_array_t map_wakeup_retire(map_array_t map, cdb_packet_t cdb,
                                                     retire_packet_t retire);
        map_array_t result;
        result = map;
        for (int i = 0; i < arch_regs; i++) begin
            if (cdb.valid && result[i].tag != '0 && result[i].tag == cdb.tag) begin
                result[i].ready = 1'b1;
            end
            if (retire.valid && result[i].tag == retire.tag) begin
                result[i] = '0;
            end
        end
        return result;
    endfunction

endpackage

// File: map_table.sv
// live register map table
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             accept,
    input  dispatch_packet_t dispatch,
    input  rob_tag_t         new_tag,
    input  cdb_packet_t      cdb,
    input  retire_packet_t   retire,
    input  logic             restore,
    input  map_array_t       restore_map,
    input  rob_tag_t         squash_tail,
    output map_entry_t       entry_a,
    output map_entry_t       entry_b,
    output map_array_t       live_map
);

    map_array_t map_q;
    map_array_t map_d;
    map_array_t restored;
    rob_tag_t   youngest_tag;
    logic       write_en;

    // a rename only lands on a real destination
    assign write_en = accept && dispatch.has_dest && (dispatch.dest_reg != '0);

    // youngest allocated tag sits one slot behind the next free tag
    assign youngest_tag = slot_to_tag(tag_to_slot(new_tag) - rob_slot_t'(1));

    // register 0 and unused sources read as the register file
    always_comb begin
        entry_a = '0;
        entry_b = '0;
        if (dispatch.rs1_valid && dispatch.rs1_reg != '0) begin
            entry_a = map_q[dispatch.rs1_reg];
        end
        if (dispatch.rs2_valid && dispatch.rs2_reg != '0) begin
            entry_b = map_q[dispatch.rs2_reg];
        end
    end

    // checkpoint copy with anything younger than the branch removed
    always_comb begin
        restored = restore_map;
        for (int i = 0; i < arch_regs; i++) begin
            if (tag_in_flight_after(restored[i].tag, squash_tail, youngest_tag)) begin
                restored[i] = '0;
            end
        end
    end

    always_comb begin
        map_d = restore ? restored : map_q;
        // the restored copy still needs this cycle's wakeup and retire
        map_d = map_wakeup_retire(map_d, cdb, retire);
        if (write_en) begin
            map_d[dispatch.dest_reg].tag = new_tag;
            map_d[dispatch.dest_reg].ready = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            map_q <= '0;
        end else begin
            map_q <= map_d;
        end
    end

    assign live_map = map_q;

    // register 0 is never renamed, so its entry stays empty for good
    a_reg0_never_renamed: assert property (
        @(posedge clock) disable iff (reset)
        map_q[0] == '0
    );

endmodule

// File: checkpoint_store.sv
// branch checkpoint storage
`timescale 1ns/1ps

module checkpoint_store import rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             accept,
    input  dispatch_packet_t dispatch,
    input  rob_tag_t         new_tag,
    input  map_array_t       live_map,
    input  cdb_packet_t      cdb,
    input  retire_packet_t   retire,
    input  resolve_packet_t  resolve,
    input  rob_tag_t         tail_tag,
    output logic             checkpoint_free,
    output map_array_t       restore_map
);

    map_array_t                  cp_map [checkpoint_count];
    rob_tag_t                    cp_tag [checkpoint_count];
    logic [checkpoint_count-1:0] cp_busy;

    logic                        alloc_en;
    cp_idx_t                     alloc_idx;
    map_array_t                  snap_map;
    logic [checkpoint_count-1:0] match_vec;
    cp_idx_t                     match_idx;
    logic [checkpoint_count-1:0] release_vec;

    assign checkpoint_free = ~&cp_busy;
    assign alloc_en = accept && dispatch.is_branch;

    // lowest free slot wins
    always_comb begin
        alloc_idx = '0;
        for (int i = checkpoint_count - 1; i >= 0; i--) begin
            if (!cp_busy[i]) begin
                alloc_idx = cp_idx_t'(i);
            end
        end
    end

    // the copy taken now must match what the live table holds next cycle
    always_comb begin
        snap_map = map_wakeup_retire(live_map, cdb, retire);
        if (dispatch.has_dest && dispatch.dest_reg != '0) begin
            snap_map[dispatch.dest_reg].tag = new_tag;
            snap_map[dispatch.dest_reg].ready = 1'b0;
        end
    end

    // find the resolving branch's slot
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < checkpoint_count; i++) begin
            match_vec[i] = cp_busy[i] && (cp_tag[i] == resolve.tag);
        end
        for (int i = checkpoint_count - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                match_idx = cp_idx_t'(i);
            end
        end
    end

    assign restore_map = cp_map[match_idx];

    // a mispredict also drops every younger branch still holding a slot
    always_comb begin
        for (int i = 0; i < checkpoint_count; i++) begin
            release_vec[i] = resolve.valid &&
                             (match_vec[i] ||
                              (resolve.mispredict && cp_busy[i] &&
                               tag_in_flight_after(cp_tag[i], resolve.tag, tail_tag)));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cp_busy <= '0;
            for (int i = 0; i < checkpoint_count; i++) begin
                cp_tag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < checkpoint_count; i++) begin
                if (release_vec[i]) begin
                    cp_busy[i] <= 1'b0;
                end
            end
            if (alloc_en) begin
                cp_busy[alloc_idx] <= 1'b1;
                cp_tag[alloc_idx] <= new_tag;
            end
        end
    end

    // stored maps track wakeups and retires like the live table
    always_ff @(posedge clock) begin
        for (int i = 0; i < checkpoint_count; i++) begin
            if (cp_busy[i]) begin
                cp_map[i] <= map_wakeup_retire(cp_map[i], cdb, retire);
            end
        end
        if (alloc_en) begin
            cp_map[alloc_idx] <= snap_map;
        end
    end

    // dispatch gating at the top must hold branches back when full
    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset)
        alloc_en |-> !(&cp_busy)
    );

    // every resolved branch was checkpointed at dispatch
    a_resolve_has_slot: assert property (
        @(posedge clock) disable iff (reset)
        resolve.valid |-> |match_vec
    );

endmodule

// File: rob_tracker.sv
// reorder buffer tag bookkeeping
`timescale 1ns/1ps

module rob_tracker import rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             accept,
    input  dispatch_packet_t dispatch,
    input  cdb_packet_t      cdb,
    input  resolve_packet_t  resolve,
    output rob_tag_t         new_tag,
    output rob_tag_t         tail_tag,
    output logic             rob_full,
    output retire_packet_t   retire
);

    rob_slot_t              head_q;
    rob_slot_t              tail_q;
    rob_count_t             count_q;
    rob_count_t             count_d;
    logic [rob_depth-1:0]   busy_q;
    logic [rob_depth-1:0]   done_q;
    logic [rob_depth-1:0]   has_dest_q;
    reg_idx_t               dest_reg_q [rob_depth];

    logic                   retire_fire;
    logic                   mispredict;
    rob_slot_t              restored_tail;
    rob_slot_t              span;

    assign new_tag = slot_to_tag(tail_q);
    assign tail_tag = slot_to_tag(tail_q - rob_slot_t'(1));
    assign rob_full = (count_q == rob_count_t'(rob_depth));

    // head retires once completed
    assign retire_fire = busy_q[head_q] && done_q[head_q];
    assign retire.valid = retire_fire;
    assign retire.tag = slot_to_tag(head_q);
    assign retire.has_dest = has_dest_q[head_q];
    assign retire.dest_reg = dest_reg_q[head_q];

    assign mispredict = resolve.valid && resolve.mispredict;
    assign restored_tail = tag_to_slot(resolve.tag) + rob_slot_t'(1);

    always_comb begin
        span = restored_tail - (head_q + rob_slot_t'(retire_fire));
        if (mispredict) begin
            // zero span means the branch is the last entry of a full ring
            count_d = (span == '0) ? rob_count_t'(rob_depth) : rob_count_t'(span);
        end else begin
            count_d = count_q + rob_count_t'(accept) - rob_count_t'(retire_fire);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            busy_q <= '0;
            done_q <= '0;
        end else begin
            count_q <= count_d;
            if (cdb.valid) begin
                done_q[tag_to_slot(cdb.tag)] <= 1'b1;
            end
            // branches complete through their resolve
            if (resolve.valid) begin
                done_q[tag_to_slot(resolve.tag)] <= 1'b1;
            end
            if (accept) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q <= tail_q + rob_slot_t'(1);
            end
            if (retire_fire) begin
                busy_q[head_q] <= 1'b0;
                head_q <= head_q + rob_slot_t'(1);
            end
            if (mispredict) begin
                tail_q <= restored_tail;
                for (int i = 0; i < rob_depth; i++) begin
                    if (tag_in_flight_after(slot_to_tag(rob_slot_t'(i)), resolve.tag,
                                            tail_tag)) begin
                        busy_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            has_dest_q[tail_q] <= dispatch.has_dest && (dispatch.dest_reg != '0);
            dest_reg_q[tail_q] <= dispatch.dest_reg;
        end
    end

    // functional units only broadcast tags handed out at dispatch
    a_cdb_tag_busy: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag != '0) && busy_q[tag_to_slot(cdb.tag)]
    );

endmodule

// File: rename_unit.sv
// register rename unit top
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  dispatch_packet_t dispatch,
    output logic             dispatch_ready,
    output operand_packet_t  operands,
    input  cdb_packet_t      cdb,
    input  resolve_packet_t  resolve,
    output retire_packet_t   retire
);

    logic       accept;
    logic       mispredict;
    logic       rob_full;
    logic       checkpoint_free;
    rob_tag_t   new_tag;
    rob_tag_t   tail_tag;
    map_entry_t entry_a;
    map_entry_t entry_b;
    map_array_t live_map;
    map_array_t restore_map;

    assign mispredict = resolve.valid && resolve.mispredict;

    // hold dispatch while recovering, when the ROB is full or a branch has no slot
    assign dispatch_ready = !rob_full && !(dispatch.is_branch && !checkpoint_free) &&
                            !mispredict;
    assign accept = dispatch_valid && dispatch_ready;

    assign operands.entry_a = entry_a;
    assign operands.entry_b = entry_b;
    assign operands.new_tag = new_tag;

    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .accept      (accept),
        .dispatch    (dispatch),
        .new_tag     (new_tag),
        .cdb         (cdb),
        .retire      (retire),
        .restore     (mispredict),
        .restore_map (restore_map),
        .squash_tail (resolve.tag),
        .entry_a     (entry_a),
        .entry_b     (entry_b),
        .live_map    (live_map)
    );

    checkpoint_store u_checkpoint_store (
        .clock           (clock),
        .reset           (reset),
        .accept          (accept),
        .dispatch        (dispatch),
        .new_tag         (new_tag),
        .live_map        (live_map),
        .cdb             (cdb),
        .retire          (retire),
        .resolve         (resolve),
        .tail_tag        (tail_tag),
        .checkpoint_free (checkpoint_free),
        .restore_map     (restore_map)
    );

    rob_tracker u_rob_tracker (
        .clock    (clock),
        .reset    (reset),
        .accept   (accept),
        .dispatch (dispatch),
        .cdb      (cdb),
        .resolve  (resolve),
        .new_tag  (new_tag),
        .tail_tag (tail_tag),
        .rob_full (rob_full),
        .retire   (retire)
    );

endmodule

// File: tb_vectors.svh
// rename unit test vectors
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // column order is dispatch valid | has_dest dest rs1_valid rs1 rs2_valid rs2 branch
    // | cdb valid tag | resolve valid mispredict tag | ready
    // | a tag ready b tag ready new_tag | retire v tag hd dest
    task automatic load_vectors();
        // reset state, then three plain renames
        add_row(1, 1, 1, 1, 2, 1, 3, 0,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 1,  0, 0, 0, 0);
        add_row(1, 1, 2, 1, 1, 1, 1, 0,  0, 0,  0, 0, 0,  1,  1, 0, 1, 0, 2,  0, 0, 0, 0);
        add_row(1, 1, 1, 1, 1, 1, 2, 0,  0, 0,  0, 0, 0,  1,  1, 0, 2, 0, 3,  0, 0, 0, 0);
        // wakeup and in-order retire with tag 3 finishing before tag 2
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  1, 1,  0, 0, 0,  1,  3, 0, 2, 0, 4,  0, 0, 0, 0);
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  1, 3,  0, 0, 0,  1,  3, 0, 2, 0, 4,  1, 1, 1, 1);
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  1, 2,  0, 0, 0,  1,  3, 1, 2, 0, 4,  0, 0, 0, 0);
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  0, 0,  0, 0, 0,  1,  3, 1, 2, 1, 4,  1, 2, 1, 2);
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  0, 0,  0, 0, 0,  1,  3, 1, 0, 0, 4,  1, 3, 1, 1);
        add_row(0, 0, 0, 1, 1, 1, 2, 0,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 4,  0, 0, 0, 0);
        // branch resolved correctly keeps the renames behind it
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 4,  0, 0, 0, 0);
        add_row(1, 1, 5, 1, 5, 0, 0, 0,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 5,  0, 0, 0, 0);
        add_row(1, 1, 6, 1, 5, 0, 0, 0,  0, 0,  1, 0, 4,  1,  5, 0, 0, 0, 6,  0, 0, 0, 0);
        add_row(0, 0, 0, 1, 5, 1, 6, 0,  0, 0,  0, 0, 0,  1,  5, 0, 6, 0, 7,  1, 4, 0, 0);
        // four branches fill the checkpoints, then the ROB fills up
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 7,  0, 0, 0, 0);
        add_row(1, 1, 7, 1, 6, 0, 0, 0,  0, 0,  0, 0, 0,  1,  6, 0, 0, 0, 8,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 1,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 2,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 3,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  0,  0, 0, 0, 0, 4,  0, 0, 0, 0);
        add_row(1, 1, 8, 0, 0, 0, 0, 0,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 4,  0, 0, 0, 0);
        add_row(1, 1, 9, 1, 7, 1, 5, 0,  0, 0,  0, 0, 0,  0,  8, 0, 5, 0, 5,  0, 0, 0, 0);
        // mispredict of tag 7 squashes tags 8 and 1 to 4
        add_row(1, 1, 9, 1, 7, 1, 5, 0,  0, 0,  1, 1, 7,  0,  8, 0, 5, 0, 5,  0, 0, 0, 0);
        add_row(1, 1, 9, 1, 7, 1, 5, 0,  0, 0,  0, 0, 0,  1,  0, 0, 5, 0, 8,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 1,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 2,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 3,  0, 0, 0, 0);
        add_row(1, 0, 0, 0, 0, 0, 0, 1,  0, 0,  0, 0, 0,  1,  0, 0, 0, 0, 4,  0, 0, 0, 0);
        // restore that overlaps a wakeup and a retire of the same tag
        add_row(0, 0, 0, 1, 9, 0, 0, 0,  1, 5,  0, 0, 0,  0,  8, 0, 0, 0, 5,  0, 0, 0, 0);
        add_row(0, 0, 0, 1, 5, 1, 9, 0,  0, 0,  1, 1, 1,  0,  5, 1, 8, 0, 5,  1, 5, 1, 5);
        add_row(0, 0, 0, 1, 5, 1, 6, 0,  0, 0,  0, 0, 0,  1,  0, 0, 6, 0, 2,  0, 0, 0, 0);
    endtask

`endif

// File: tb_rename_unit.sv
// register rename unit testbench
`timescale 1ns/1ps

module tb_rename_unit import rename_pkg::*; ();

    // one table row holds the inputs for a cycle and the outputs expected in it
    typedef struct packed {
        logic             dispatch_valid;
        dispatch_packet_t dispatch;
        cdb_packet_t      cdb;
        resolve_packet_t  resolve;
        logic             ready;
        operand_packet_t  operands;
        retire_packet_t   retire;
    } vector_t;

    logic             clock;
    logic             reset;
    logic             dispatch_valid;
    dispatch_packet_t dispatch;
    logic             dispatch_ready;
    operand_packet_t  operands;
    cdb_packet_t      cdb;
    resolve_packet_t  resolve;
    retire_packet_t   retire;

    vector_t vectors[$];
    int      cycle_count;
    int      cycle_limit;

    rename_unit u_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .operands       (operands),
        .cdb            (cdb),
        .resolve        (resolve),
        .retire         (retire)
    );

    always #5 clock = ~clock;

    task automatic add_row(
        input int dv,
        input int has_dest, input int dest,
        input int rs1_valid, input int rs1, input int rs2_valid, input int rs2,
        input int branch,
        input int cdb_valid, input int cdb_tag,
        input int res_valid, input int res_mispredict, input int res_tag,
        input int exp_ready,
        input int a_tag, input int a_ready, input int b_tag, input int b_ready,
        input int exp_new_tag,
        input int ret_valid, input int ret_tag, input int ret_has_dest, input int ret_dest
    );
        vector_t v;
        v = '0;
        v.dispatch_valid = dv[0];
        v.dispatch.has_dest = has_dest[0];
        v.dispatch.dest_reg = reg_idx_t'(dest);
        v.dispatch.rs1_valid = rs1_valid[0];
        v.dispatch.rs1_reg = reg_idx_t'(rs1);
        v.dispatch.rs2_valid = rs2_valid[0];
        v.dispatch.rs2_reg = reg_idx_t'(rs2);
        v.dispatch.is_branch = branch[0];
        v.cdb.valid = cdb_valid[0];
        v.cdb.tag = rob_tag_t'(cdb_tag);
        v.resolve.valid = res_valid[0];
        v.resolve.mispredict = res_mispredict[0];
        v.resolve.tag = rob_tag_t'(res_tag);
        v.ready = exp_ready[0];
        v.operands.entry_a.tag = rob_tag_t'(a_tag);
        v.operands.entry_a.ready = a_ready[0];
        v.operands.entry_b.tag = rob_tag_t'(b_tag);
        v.operands.entry_b.ready = b_ready[0];
        v.operands.new_tag = rob_tag_t'(exp_new_tag);
        v.retire.valid = ret_valid[0];
        v.retire.tag = rob_tag_t'(ret_tag);
        v.retire.has_dest = ret_has_dest[0];
        v.retire.dest_reg = reg_idx_t'(ret_dest);
        vectors.push_back(v);
    endtask

`include "tb_vectors.svh"

    task automatic apply_row(input vector_t v);
        dispatch_valid <= v.dispatch_valid;
        dispatch <= v.dispatch;
        cdb <= v.cdb;
        resolve <= v.resolve;
    endtask

    task automatic check_field(input int row, input string field, input int expected,
                               input int actual);
        assert (actual == expected) else begin
            $display("[ERROR] %0t: row %0d %s expected %0d got %0d", $time, row, field,
                     expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input int row, input vector_t v);
        check_field(row, "dispatch_ready", int'(v.ready), int'(dispatch_ready));
        check_field(row, "entry_a.tag", int'(v.operands.entry_a.tag),
                    int'(operands.entry_a.tag));
        check_field(row, "entry_a.ready", int'(v.operands.entry_a.ready),
                    int'(operands.entry_a.ready));
        check_field(row, "entry_b.tag", int'(v.operands.entry_b.tag),
                    int'(operands.entry_b.tag));
        check_field(row, "entry_b.ready", int'(v.operands.entry_b.ready),
                    int'(operands.entry_b.ready));
        check_field(row, "new_tag", int'(v.operands.new_tag), int'(operands.new_tag));
        check_field(row, "retire.valid", int'(v.retire.valid), int'(retire.valid));
        // the other retire fields only mean something on a valid retire
        if (v.retire.valid) begin
            check_field(row, "retire.tag", int'(v.retire.tag), int'(retire.tag));
            check_field(row, "retire.has_dest", int'(v.retire.has_dest),
                        int'(retire.has_dest));
            check_field(row, "retire.dest_reg", int'(v.retire.dest_reg),
                        int'(retire.dest_reg));
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the vector table did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        cdb = '0;
        resolve = '0;
        load_vectors();
        cycle_limit = 4 * vectors.size() + 100;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        // outputs settle by the falling edge and the next rising edge commits the row
        foreach (vectors[i]) begin
            apply_row(vectors[i]);
            @(negedge clock);
            check_outputs(i, vectors[i]);
            @(posedge clock);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: rename_unit.f
+incdir+.
rename_pkg.sv
map_table.sv
checkpoint_store.sv
rob_tracker.sv
rename_unit.sv
tb_rename_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= rename_unit.f
BUILD_DIR ?= build
FLAGS     ?= -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
